//--- hdl/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

   timeunit 1ns;
   timeprecision 1ns;

   // instruction field widths
   localparam int WORD_W   = 32;
   localparam int OPCODE_W = 6;
   localparam int FUNCT_W  = 6;
   localparam int REG_W    = 5;
   localparam int SHAMT_W  = 5;
   localparam int IMM16_W  = 16;
   localparam int IMM26_W  = 26;

   typedef logic [WORD_W-1:0]  word_t;
   typedef logic [REG_W-1:0]   regbits_t;
   typedef logic [IMM16_W-1:0] imm16_t;
   typedef logic [IMM26_W-1:0] imm26_t;
   typedef logic [SHAMT_W-1:0] shamt_t;

   // major opcodes of the supported subset
   typedef enum logic [OPCODE_W-1:0] {
      RTYPE   = 6'h00,
      J       = 6'h02,
      JAL     = 6'h03,
      BEQ     = 6'h04,
      BNE     = 6'h05,
      ADDIU   = 6'h09,
      SLTI    = 6'h0a,
      ANDI    = 6'h0c,
      ORI     = 6'h0d,
      XORI    = 6'h0e,
      LUI     = 6'h0f,
      LW      = 6'h23,
      SW      = 6'h2b,
      HALT_OP = 6'h3f
   } opcode_t;

   // r-type function codes
   typedef enum logic [FUNCT_W-1:0] {
      SLL  = 6'h00,
      SRL  = 6'h02,
      JR   = 6'h08,
      ADDU = 6'h21,
      SUBU = 6'h23,
      AND  = 6'h24,
      OR   = 6'h25,
      XOR  = 6'h26,
      NOR  = 6'h27,
      SLT  = 6'h2a,
      SLTU = 6'h2b
   } funct_t;

   localparam word_t    HALT_WORD = 32'hffff_ffff;
   localparam word_t    PC_RESET  = 32'h0000_0000;
   // jal return address register
   localparam regbits_t LINK_REG  = 5'd31;

endpackage

`default_nettype wire

//--- hdl/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

   timeunit 1ns;
   timeprecision 1ns;

   localparam int ALUOP_W = 4;

   // bit positions inside alu_flags_t
   localparam int FLAG_N = 2;
   localparam int FLAG_V = 1;
   localparam int FLAG_Z = 0;

   typedef enum logic [ALUOP_W-1:0] {
      ALU_SLL  = 4'd0,
      ALU_SRL  = 4'd1,
      ALU_ADD  = 4'd2,
      ALU_SUB  = 4'd3,
      ALU_AND  = 4'd4,
      ALU_OR   = 4'd5,
      ALU_XOR  = 4'd6,
      ALU_NOR  = 4'd7,
      ALU_SLT  = 4'd8,
      ALU_SLTU = 4'd9
   } aluop_t;

   // register write destination
   typedef enum logic [1:0] {
      RD  = 2'd0,
      RT  = 2'd1,
      R31 = 2'd2
   } regdst_t;

   // second alu operand
   typedef enum logic [1:0] {
      REG   = 2'd0,
      EXT   = 2'd1,
      UPPER = 2'd2
   } alusrc_t;

   typedef enum logic [1:0] {
      SEQ    = 2'd0,
      BRANCH = 2'd1,
      JUMP   = 2'd2,
      JREG   = 2'd3
   } pcsrc_t;

   typedef logic [2:0] alu_flags_t;

endpackage

`default_nettype wire

//--- hdl/core_block_ifs.sv
`timescale 1ns/1ns
`default_nettype none

interface control_unit_if import cpu_types_pkg::*, cpu_ctrl_pkg::*; ();
   word_t      instr;
   alu_flags_t alu_flags;
   regbits_t   rs, rt, rd;
   imm16_t     imm16;
   shamt_t     shamt;
   logic       extop;
   aluop_t     alu_op;
   alusrc_t    alu_src;
   regdst_t    regdst;
   logic       memtoreg, regwr, dread, dwrite;
   pcsrc_t     pc_src;
   logic       halt;

   modport cu (
      input  instr, alu_flags,
      output rs, rt, rd, imm16, shamt, extop, alu_op, alu_src, regdst,
             memtoreg, regwr, dread, dwrite, pc_src, halt
   );
   modport dp (
      output instr, alu_flags,
      input  rs, rt, rd, imm16, shamt, extop, alu_op, alu_src, regdst,
             memtoreg, regwr, dread, dwrite, pc_src, halt
   );
endinterface

interface register_file_if import cpu_types_pkg::*; ();
   regbits_t rsel1, rsel2, wsel;
   word_t    wdat, rdat1, rdat2;
   logic     wen;

   modport rf (input rsel1, rsel2, wsel, wdat, wen, output rdat1, rdat2);
   modport dp (output rsel1, rsel2, wsel, wdat, wen, input rdat1, rdat2);
endinterface

interface alu_if import cpu_types_pkg::*, cpu_ctrl_pkg::*; ();
   word_t      op1, op2, res;
   aluop_t     opcode;
   shamt_t     shamt;
   alu_flags_t flags;

   modport alu (input op1, op2, opcode, shamt, output res, flags);
   modport dp (output op1, op2, opcode, shamt, input res, flags);
endinterface

interface pc_if import cpu_types_pkg::*, cpu_ctrl_pkg::*; ();
   pcsrc_t pc_src;
   imm16_t imm16;
   imm26_t imm26;
   word_t  jreg, imemaddr, pc_plus4;
   logic   pc_en, halt;
   // registered halt that stays high until reset
   logic   halted;

   modport pc (input pc_src, imm16, imm26, jreg, pc_en, halt,
               output imemaddr, pc_plus4, halted);
   modport dp (output pc_src, imm16, imm26, jreg, pc_en, halt,
               input imemaddr, pc_plus4, halted);
endinterface

interface request_unit_if ();
   logic regwr, dread, dwrite, ihit, dhit, halt;
   logic imemren, dmemren, dmemwen, wen;

   modport rq (input regwr, dread, dwrite, ihit, dhit, halt,
               output imemren, dmemren, dmemwen, wen);
   modport dp (output regwr, dread, dwrite, ihit, dhit, halt,
               input imemren, dmemren, dmemwen, wen);
endinterface

interface datapath_cache_if import cpu_types_pkg::*; ();
   logic  ihit, dhit, halt;
   logic  imemren, dmemren, dmemwen;
   word_t imemload, dmemload;
   word_t imemaddr, dmemaddr, dmemstore;

   modport dp (
      input  ihit, imemload, dhit, dmemload,
      output halt, imemren, imemaddr, dmemren, dmemwen, dmemaddr, dmemstore
   );
endinterface

`default_nettype wire

//--- hdl/control_unit.sv
`timescale 1ns/1ns
`default_nettype none

module control_unit import cpu_types_pkg::*, cpu_ctrl_pkg::*; (
   control_unit_if.cu cuif
);

   opcode_t op;
   funct_t  fn;

   assign op = opcode_t'(cuif.instr[31:26]);
   assign fn = funct_t'(cuif.instr[5:0]);

   always_comb begin
      // fields straight from the instruction word
      cuif.rs       = cuif.instr[25:21];
      cuif.rt       = cuif.instr[20:16];
      cuif.rd       = cuif.instr[15:11];
      cuif.shamt    = cuif.instr[10:6];
      cuif.imm16    = cuif.instr[15:0];
      // no-op defaults
      cuif.extop    = 1'b0;
      cuif.alu_op   = ALU_ADD;
      cuif.alu_src  = REG;
      cuif.regdst   = RD;
      cuif.memtoreg = 1'b0;
      cuif.regwr    = 1'b0;
      cuif.dread    = 1'b0;
      cuif.dwrite   = 1'b0;
      cuif.pc_src   = SEQ;
      cuif.halt     = 1'b0;

      case (op)
         RTYPE: begin
            cuif.regwr = 1'b1;
            case (fn)
               SLL:  cuif.alu_op = ALU_SLL;
               SRL:  cuif.alu_op = ALU_SRL;
               ADDU: cuif.alu_op = ALU_ADD;
               SUBU: cuif.alu_op = ALU_SUB;
               AND:  cuif.alu_op = ALU_AND;
               OR:   cuif.alu_op = ALU_OR;
               XOR:  cuif.alu_op = ALU_XOR;
               NOR:  cuif.alu_op = ALU_NOR;
               SLT:  cuif.alu_op = ALU_SLT;
               SLTU: cuif.alu_op = ALU_SLTU;
               JR: begin
                  cuif.regwr  = 1'b0;
                  cuif.pc_src = JREG;
               end
               default: cuif.regwr = 1'b0;
            endcase
         end
         ADDIU, SLTI: begin
            cuif.alu_op  = (op == SLTI) ? ALU_SLT : ALU_ADD;
            cuif.alu_src = EXT;
            cuif.extop   = 1'b1;
            cuif.regdst  = RT;
            cuif.regwr   = 1'b1;
         end
         ANDI, ORI, XORI: begin
            // logic immediates are zero extended
            cuif.alu_op  = (op == ANDI) ? ALU_AND : (op == ORI) ? ALU_OR : ALU_XOR;
            cuif.alu_src = EXT;
            cuif.regdst  = RT;
            cuif.regwr   = 1'b1;
         end
         LUI: begin
            // or with $0 passes the upper immediate through
            cuif.rs      = '0;
            cuif.alu_op  = ALU_OR;
            cuif.alu_src = UPPER;
            cuif.regdst  = RT;
            cuif.regwr   = 1'b1;
         end
         LW, SW: begin
            cuif.alu_src  = EXT;
            cuif.extop    = 1'b1;
            cuif.regdst   = RT;
            cuif.memtoreg = (op == LW);
            cuif.regwr    = (op == LW);
            cuif.dread    = (op == LW);
            cuif.dwrite   = (op == SW);
         end
         BEQ, BNE: begin
            cuif.alu_op = ALU_SUB;
            if (cuif.alu_flags[FLAG_Z] == (op == BEQ)) begin
               cuif.pc_src = BRANCH;
            end
         end
         J: cuif.pc_src = JUMP;
         JAL: begin
            cuif.pc_src = JUMP;
            cuif.regdst = R31;
            cuif.regwr  = 1'b1;
         end
         HALT_OP: cuif.halt = (cuif.instr == HALT_WORD);
         default: ;
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file import cpu_types_pkg::*; (
   input logic CLK,
   input logic reset,
   register_file_if.rf rfif
);

   word_t regs [32];

   always_ff @(posedge CLK) begin
      if (reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (rfif.wen && (rfif.wsel != '0)) begin
         regs[rfif.wsel] <= rfif.wdat;
      end
   end

   // $0 is hardwired to zero
   assign rfif.rdat1 = (rfif.rsel1 == '0) ? '0 : regs[rfif.rsel1];
   assign rfif.rdat2 = (rfif.rsel2 == '0) ? '0 : regs[rfif.rsel2];

   wsel_known_a: assert property (
      @(posedge CLK) disable iff (reset) rfif.wen |-> !$isunknown(rfif.wsel)
   );

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import cpu_types_pkg::*, cpu_ctrl_pkg::*; (
   alu_if.alu aluif
);

   word_t res;
   logic  ovf;

   always_comb begin
      ovf = 1'b0;
      case (aluif.opcode)
         // shifts act on rt, which arrives as op2
         ALU_SLL:  res = aluif.op2 << aluif.shamt;
         ALU_SRL:  res = aluif.op2 >> aluif.shamt;
         ALU_ADD: begin
            res = aluif.op1 + aluif.op2;
            ovf = (aluif.op1[31] == aluif.op2[31]) && (res[31] != aluif.op1[31]);
         end
         ALU_SUB: begin
            res = aluif.op1 - aluif.op2;
            ovf = (aluif.op1[31] != aluif.op2[31]) && (res[31] != aluif.op1[31]);
         end
         ALU_AND:  res = aluif.op1 & aluif.op2;
         ALU_OR:   res = aluif.op1 | aluif.op2;
         ALU_XOR:  res = aluif.op1 ^ aluif.op2;
         ALU_NOR:  res = ~(aluif.op1 | aluif.op2);
         ALU_SLT:  res = {31'b0, $signed(aluif.op1) < $signed(aluif.op2)};
         ALU_SLTU: res = {31'b0, aluif.op1 < aluif.op2};
         default:  res = '0;
      endcase
   end

   assign aluif.res = res;

   always_comb begin
      aluif.flags         = '0;
      aluif.flags[FLAG_N] = res[31];
      aluif.flags[FLAG_V] = ovf;
      aluif.flags[FLAG_Z] = (res == '0);
   end

endmodule

`default_nettype wire

//--- hdl/pc.sv
`timescale 1ns/1ns
`default_nettype none

module pc import cpu_types_pkg::*, cpu_ctrl_pkg::*; (
   input logic CLK,
   input logic reset,
   pc_if.pc pcif
);

   word_t pc_q, next_pc, br_off;
   logic  halted_q;

   assign pcif.pc_plus4 = pc_q + 32'd4;
   // sign extended word offset
   assign br_off = {{14{pcif.imm16[15]}}, pcif.imm16, 2'b00};

   always_comb begin
      case (pcif.pc_src)
         BRANCH:  next_pc = pcif.pc_plus4 + br_off;
         JUMP:    next_pc = {pcif.pc_plus4[31:28], pcif.imm26, 2'b00};
         JREG:    next_pc = pcif.jreg;
         default: next_pc = pcif.pc_plus4;
      endcase
   end

   always_ff @(posedge CLK) begin
      if (reset) begin
         pc_q     <= PC_RESET;
         halted_q <= 1'b0;
      end else if (pcif.pc_en) begin
         // a halt freezes the pc on its own address
         if (pcif.halt) begin
            halted_q <= 1'b1;
         end else begin
            pc_q <= next_pc;
         end
      end
   end

   assign pcif.imemaddr = pc_q;
   assign pcif.halted   = halted_q;

   pc_aligned_a: assert property (
      @(posedge CLK) disable iff (reset)
      pcif.pc_en && !pcif.halt |=> pcif.imemaddr[1:0] == 2'b00
   );

endmodule

`default_nettype wire

//--- hdl/request_unit.sv
`timescale 1ns/1ns
`default_nettype none

module request_unit (
   input logic CLK,
   input logic reset,
   request_unit_if.rq rqif
);

   logic ren_q, wen_q;
   logic pending, start;

   assign pending = ren_q | wen_q;
   // instruction accepted this cycle
   assign start   = rqif.ihit & ~pending & ~rqif.halt;

   always_ff @(posedge CLK) begin
      if (reset) begin
         ren_q <= 1'b0;
         wen_q <= 1'b0;
      end else if (pending && rqif.dhit) begin
         ren_q <= 1'b0;
         wen_q <= 1'b0;
      end else if (start) begin
         ren_q <= rqif.dread;
         wen_q <= rqif.dwrite;
      end
   end

   assign rqif.imemren = ~rqif.halt;
   assign rqif.dmemren = ren_q;
   assign rqif.dmemwen = wen_q;

   // loads write back only when their data arrives
   assign rqif.wen = rqif.regwr & ((start & ~rqif.dread) | (ren_q & rqif.dhit));

   one_request_a: assert property (
      @(posedge CLK) disable iff (reset) !(rqif.dmemren && rqif.dmemwen)
   );

endmodule

`default_nettype wire

//--- hdl/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath import cpu_types_pkg::*, cpu_ctrl_pkg::*; (
   input logic CLK,
   input logic reset,
   datapath_cache_if.dp dpif
);

   control_unit_if  cuif ();
   register_file_if rfif ();
   alu_if           aluif ();
   pc_if            pcif ();
   request_unit_if  rqif ();

   control_unit  control_unit_i  (.cuif(cuif));
   register_file register_file_i (.CLK(CLK), .reset(reset), .rfif(rfif));
   alu           alu_i           (.aluif(aluif));
   pc            pc_i            (.CLK(CLK), .reset(reset), .pcif(pcif));
   request_unit  request_unit_i  (.CLK(CLK), .reset(reset), .rqif(rqif));

   logic  pending;
   word_t instr_q;

   assign pending = rqif.dmemren | rqif.dmemwen;

   // keeps the memory instruction decoded while its data access is open
   always_ff @(posedge CLK) begin
      if (dpif.ihit && !pending) begin
         instr_q <= dpif.imemload;
      end
   end

   assign cuif.instr     = pending ? instr_q : dpif.imemload;
   assign cuif.alu_flags = aluif.flags;

   // register file
   assign rfif.rsel1 = cuif.rs;
   assign rfif.rsel2 = cuif.rt;
   assign rfif.wen   = rqif.wen;

   always_comb begin
      case (cuif.regdst)
         RT:      rfif.wsel = cuif.rt;
         R31:     rfif.wsel = LINK_REG;
         default: rfif.wsel = cuif.rd;
      endcase
   end

   always_comb begin
      if (cuif.regdst == R31) begin
         rfif.wdat = pcif.pc_plus4;
      end else if (cuif.memtoreg) begin
         rfif.wdat = dpif.dmemload;
      end else begin
         rfif.wdat = aluif.res;
      end
   end

   // alu operands
   assign aluif.op1    = rfif.rdat1;
   assign aluif.opcode = cuif.alu_op;
   assign aluif.shamt  = cuif.shamt;

   always_comb begin
      case (cuif.alu_src)
         EXT: begin
            aluif.op2 = cuif.extop ? {{16{cuif.imm16[15]}}, cuif.imm16}
                                   : {16'b0, cuif.imm16};
         end
         UPPER:   aluif.op2 = {cuif.imm16, 16'b0};
         default: aluif.op2 = rfif.rdat2;
      endcase
   end

   assign dpif.dmemaddr  = aluif.res;
   assign dpif.dmemstore = rfif.rdat2;

   // request unit
   assign rqif.regwr   = cuif.regwr;
   assign rqif.dread   = cuif.dread;
   assign rqif.dwrite  = cuif.dwrite;
   assign rqif.ihit    = dpif.ihit;
   assign rqif.dhit    = dpif.dhit;
   assign rqif.halt    = pcif.halted;
   assign dpif.imemren = rqif.imemren;
   assign dpif.dmemren = rqif.dmemren;
   assign dpif.dmemwen = rqif.dmemwen;

   // program counter
   assign pcif.pc_src   = cuif.pc_src;
   assign pcif.imm16    = cuif.imm16;
   assign pcif.imm26    = cuif.instr[25:0];
   assign pcif.jreg     = rfif.rdat1;
   assign pcif.pc_en    = dpif.ihit & ~pending & ~pcif.halted;
   assign pcif.halt     = cuif.halt;
   assign dpif.imemaddr = pcif.imemaddr;

   // combinational on the halt fetch, then held by the pc
   assign dpif.halt = (cuif.halt & dpif.ihit) | pcif.halted;

endmodule

`default_nettype wire

//--- hdl/mips_core.sv
`timescale 1ns/1ns
`default_nettype none

module mips_core import cpu_types_pkg::*; (
   input  logic  CLK,
   input  logic  reset,
   input  logic  ihit,
   input  word_t imemload,
   input  logic  dhit,
   input  word_t dmemload,
   output logic  halt,
   output logic  imemren,
   output word_t imemaddr,
   output logic  dmemren,
   output logic  dmemwen,
   output word_t dmemaddr,
   output word_t dmemstore
);

   datapath_cache_if dcif ();

   datapath datapath_i (.CLK(CLK), .reset(reset), .dpif(dcif));

   // memory side inputs
   assign dcif.ihit     = ihit;
   assign dcif.imemload = imemload;
   assign dcif.dhit     = dhit;
   assign dcif.dmemload = dmemload;

   assign halt      = dcif.halt;
   assign imemren   = dcif.imemren;
   assign imemaddr  = dcif.imemaddr;
   assign dmemren   = dcif.dmemren;
   assign dmemwen   = dcif.dmemwen;
   assign dmemaddr  = dcif.dmemaddr;
   assign dmemstore = dcif.dmemstore;

endmodule

`default_nettype wire

//--- bench/mips_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mips_core_tb import cpu_types_pkg::*; ();

   logic  CLK = 1'b0;
   logic  reset;
   logic  ihit, dhit;
   word_t imemload, dmemload;
   logic  halt, imemren, dmemren, dmemwen;
   word_t imemaddr, dmemaddr, dmemstore;

   // 4 KB of word addressed memory
   word_t mem [0:1023];

   word_t exp_addr [$];
   word_t exp_data [$];
   word_t halt_addr;
   int    prog_words = 0;
   int    store_idx = 0;
   int    seed = 32'hd281_93cc;

   mips_core mips_core_i (
      .CLK       (CLK),
      .reset     (reset),
      .ihit      (ihit),
      .imemload  (imemload),
      .dhit      (dhit),
      .dmemload  (dmemload),
      .halt      (halt),
      .imemren   (imemren),
      .imemaddr  (imemaddr),
      .dmemren   (dmemren),
      .dmemwen   (dmemwen),
      .dmemaddr  (dmemaddr),
      .dmemstore (dmemstore)
   );

   always #10 CLK = ~CLK;

   task automatic check_value(input word_t actual, input word_t expected, input string what);
      if (actual !== expected) begin
         $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
         $display("TESTBENCH FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic abort_run(input string why);
      $display("ERROR at %0t ns: %s", $time, why);
      $display("TESTBENCH FAILED");
      $fatal(1, "run aborted");
   endtask

   task automatic load_vectors();
      int fd;
      int code;
      int done;
      logic [7:0] tag;
      logic [8*128-1:0] line_buf;
      word_t addr, data, fill;
      // background pattern unique per word
      for (int i = 0; i < 1024; i++) begin
         fill = i;
         mem[i] = {~fill[15:0], fill[15:0]};
      end
      done = 0;
      fd = $fopen("bench/program_vectors.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open bench/program_vectors.txt");
      end
      while (done == 0) begin
         code = $fscanf(fd, " %c", tag);
         if (code != 1) begin
            done = 1;
         end else begin
            case (tag)
               "#": code = $fgets(line_buf, fd);
               "P", "D": begin
                  code = $fscanf(fd, " %h %h", addr, data);
                  if (code != 2) begin
                     abort_run("malformed program or data line in the vector file");
                  end
                  if (addr[31:12] != '0) begin
                     abort_run("vector address outside the model memory");
                  end
                  mem[addr[11:2]] = data;
                  if (tag == "P") begin
                     prog_words++;
                  end
               end
               "S": begin
                  code = $fscanf(fd, " %h %h", addr, data);
                  if (code != 2) begin
                     abort_run("malformed store line in the vector file");
                  end
                  exp_addr.push_back(addr);
                  exp_data.push_back(data);
               end
               "H": begin
                  code = $fscanf(fd, " %h", halt_addr);
                  if (code != 1) begin
                     abort_run("malformed halt line in the vector file");
                  end
               end
               default: abort_run("unknown line tag in the vector file");
            endcase
         end
      end
      $fclose(fd);
   endtask

   // one data access in its dhit cycle
   task automatic serve_data();
      if (dmemaddr[31:12] != '0 || dmemaddr[1:0] != 2'b00) begin
         abort_run("data access outside the model memory or not word aligned");
      end else if (dmemwen) begin
         if (store_idx >= exp_addr.size()) begin
            abort_run("store issued after all expected stores were matched");
         end
         check_value(dmemaddr, exp_addr[store_idx],
                     $sformatf("store %0d address", store_idx));
         check_value(dmemstore, exp_data[store_idx],
                     $sformatf("store %0d data", store_idx));
         store_idx++;
         mem[dmemaddr[11:2]] = dmemstore;
      end else begin
         dmemload = mem[dmemaddr[11:2]];
      end
      dhit = 1'b1;
   endtask

   // memory model answering after 1 to 4 cycles
   initial begin : memory_model
      int wait_left;
      int r;
      ihit     = 1'b0;
      dhit     = 1'b0;
      imemload = '0;
      dmemload = '0;
      wait_left = 0;
      load_vectors();
      forever begin
         @(posedge CLK);
         if (!reset) begin
            #2;
            ihit = 1'b0;
            dhit = 1'b0;
            if (dmemren || dmemwen || imemren) begin
               if (wait_left == 0) begin
                  r = $random(seed);
                  wait_left = 1 + (r & 3);
               end
               wait_left = wait_left - 1;
               if (wait_left == 0) begin
                  // no ihit while a data request is open
                  if (dmemren || dmemwen) begin
                     serve_data();
                  end else if (imemaddr[31:12] != '0) begin
                     abort_run("instruction fetch outside the model memory");
                  end else begin
                     imemload = mem[imemaddr[11:2]];
                     ihit = 1'b1;
                  end
               end
            end
         end
      end
   end

   initial begin : watchdog
      int limit;
      @(posedge CLK);
      // 40 cycles per word and 8 times over for loops
      limit = prog_words * 40 * 8;
      repeat (limit + 10) @(posedge CLK);
      $display("timeout: the core did not halt within %0d cycles", limit);
      $display("TESTBENCH FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      reset = 1'b1;
      repeat (2) @(posedge CLK);
      #2;
      reset = 1'b0;

      // state right after reset
      @(negedge CLK);
      check_value(imemaddr, PC_RESET, "imemaddr after reset");
      check_value({31'b0, imemren}, 32'd1, "imemren after reset");
      check_value({31'b0, dmemren}, 32'd0, "dmemren after reset");
      check_value({31'b0, dmemwen}, 32'd0, "dmemwen after reset");
      check_value({31'b0, halt}, 32'd0, "halt after reset");

      while (halt !== 1'b1) begin
         @(negedge CLK);
      end
      check_value(imemaddr, halt_addr, "halt address");

      // core stays quiet once halted
      repeat (10) begin
         @(negedge CLK);
         check_value({31'b0, halt}, 32'd1, "halt after halting");
         check_value({31'b0, imemren}, 32'd0, "imemren after halting");
         check_value({31'b0, dmemren}, 32'd0, "dmemren after halting");
         check_value({31'b0, dmemwen}, 32'd0, "dmemwen after halting");
      end
      check_value(store_idx, exp_addr.size(), "matched store count");

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/program_vectors.txt
# P addr word = program word, D addr word = initial data word
# S addr data = expected store in program order, H addr = expected halt address
P 00000000 24010005
P 00000004 2402FFFD
P 00000008 240A0300
P 0000000C 00221821
P 00000010 00222023
P 00000014 AD430000
P 00000018 AD440004
P 0000001C 3C051234
P 00000020 34A55678
P 00000024 00A23026
P 00000028 00A43824
P 0000002C 00A44027
P 00000030 AD450008
P 00000034 AD46000C
P 00000038 AD470010
P 0000003C AD480014
P 00000040 0041602A
P 00000044 0022682B
P 00000048 282EFFFE
P 0000004C 00057900
P 00000050 00028202
P 00000054 AD4C0018
P 00000058 AD4D001C
P 0000005C AD4E0020
P 00000060 AD4F0024
P 00000064 AD500028
P 00000068 30518F0F
P 0000006C 38B2FFFF
P 00000070 AD51002C
P 00000074 AD520030
P 00000078 240B0200
P 0000007C 8D730000
P 00000080 8D740004
P 00000084 0274A821
P 00000088 AD550034
P 0000008C AD750008
P 00000090 8D760008
P 00000094 02D3B823
P 00000098 AD570038
P 0000009C 10220005
P 000000A0 14210007
P 000000A4 10630001
P 000000A8 FFFFFFFF
P 000000AC 24180011
P 000000B0 14220001
P 000000B4 FFFFFFFF
P 000000B8 AD58003C
P 000000BC 08000031
P 000000C0 FFFFFFFF
P 000000C4 0C000035
P 000000C8 AD5F0040
P 000000CC AD590044
P 000000D0 FFFFFFFF
P 000000D4 24190077
P 000000D8 03E00008
D 00000200 00001000
D 00000204 00000234
S 00000300 00000002
S 00000304 00000008
S 00000308 12345678
S 0000030C EDCBA985
S 00000310 00000008
S 00000314 EDCBA987
S 00000318 00000001
S 0000031C 00000001
S 00000320 00000000
S 00000324 23456780
S 00000328 00FFFFFF
S 0000032C 00008F0D
S 00000330 1234A987
S 00000334 00001234
S 00000208 00001234
S 00000338 00000234
S 0000033C 00000011
S 00000340 000000C8
S 00000344 00000077
H 000000D0

//--- sources.f
hdl/cpu_types_pkg.sv
hdl/cpu_ctrl_pkg.sv
hdl/core_block_ifs.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/alu.sv
hdl/pc.sv
hdl/request_unit.sv
hdl/datapath.sv
hdl/mips_core.sv
bench/mips_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --assert -j 0 --top-module mips_core_tb \
   -f sources.f --Mdir obj_dir -o mips_core_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "build failed with status $status"
   exit "$status"
fi

./obj_dir/mips_core_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation failed with status $status"
   exit "$status"
fi

exit 0
